// ==== source/mesh_pkg.sv ====
/* shared types for the mesh node: coordinates, port directions,
   packet and link structs, router and input FIFO constants */

`default_nettype none

package mesh_pkg;

  // router geometry and buffering
  localparam int num_dirs_lp   = 5;
  localparam int fifo_els_lp   = 2;
  localparam int fifo_ptr_w_lp = $clog2(fifo_els_lp);
  localparam int fifo_cnt_w_lp = $clog2(fifo_els_lp + 1);

  // node coordinates, x grows east and y grows south
  typedef logic [2:0] x_cord_t;
  typedef logic [2:0] y_cord_t;

  typedef logic [1:0]  op_t;
  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;

  // router port order, P is the local processor
  typedef enum logic [2:0] {
    P = 3'd0,
    W,
    E,
    N,
    S
  } dir_e;

  // routing header, always the leading field of a packet
  typedef struct packed {
    y_cord_t dst_y;
    x_cord_t dst_x;
  } mesh_hdr_s;

  // request packet
  typedef struct packed {
    mesh_hdr_s hdr;
    op_t       op;
    x_cord_t   src_x;
    y_cord_t   src_y;
    addr_t     addr;
    data_t     data;
  } fwd_pkt_s;

  // response packet
  typedef struct packed {
    mesh_hdr_s hdr;
    data_t     data;
  } rev_pkt_s;

  // link payload as seen on a wire, ready travels separately
  typedef struct packed {
    logic     v;
    fwd_pkt_s pkt;
  } fwd_link_s;

  typedef struct packed {
    logic     v;
    rev_pkt_s pkt;
  } rev_link_s;

  localparam int hdr_width_lp     = $bits(mesh_hdr_s);
  localparam int fwd_pkt_width_lp = $bits(fwd_pkt_s);
  localparam int rev_pkt_width_lp = $bits(rev_pkt_s);

endpackage

`default_nettype wire

// ==== source/mesh_input_fifo.sv ====
/* two-entry input buffer for one router port,
   valid/ready on the enqueue side, valid/yumi on the dequeue side */

`timescale 1ns/1ps
`default_nettype none

module mesh_input_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               enq_v_i,
  input  logic [width_p-1:0] enq_data_i,
  output logic               enq_ready_o,

  output logic               deq_v_o,
  output logic [width_p-1:0] deq_data_o,
  input  logic               deq_yumi_i
);

  import mesh_pkg::*;

  logic [width_p-1:0]       mem_r [fifo_els_lp];
  logic [fifo_ptr_w_lp-1:0] wptr_r;
  logic [fifo_ptr_w_lp-1:0] rptr_r;
  logic [fifo_cnt_w_lp-1:0] count_r;
  logic                     enq;

  // ready only looks at occupancy, never at enq_v_i
  assign enq_ready_o = (count_r != fifo_cnt_w_lp'(fifo_els_lp));
  assign deq_v_o     = (count_r != '0);
  assign deq_data_o  = mem_r[rptr_r];
  assign enq         = enq_v_i & enq_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= (wptr_r == fifo_ptr_w_lp'(fifo_els_lp - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq_yumi_i) begin
        rptr_r <= (rptr_r == fifo_ptr_w_lp'(fifo_els_lp - 1)) ? '0 : rptr_r + 1'b1;
      end
      case ({enq, deq_yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage only
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= enq_data_i;
    end
  end

  // the allocator may only pop a head that is actually there
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) deq_yumi_i |-> deq_v_o
  );

endmodule

`default_nettype wire

// ==== source/mesh_route_decode.sv ====
/* dimension-order route decoder,
   header and node coordinates in, one-hot output port request out */

`timescale 1ns/1ps
`default_nettype none

module mesh_route_decode #(
  parameter int xy_order_p = 1
) (
  input  mesh_pkg::mesh_hdr_s              hdr_i,
  input  mesh_pkg::x_cord_t                my_x_i,
  input  mesh_pkg::y_cord_t                my_y_i,
  output logic [mesh_pkg::num_dirs_lp-1:0] req_o
);

  import mesh_pkg::*;

  dir_e x_dir;
  dir_e y_dir;
  dir_e sel_dir;

  always_comb begin
    // per-dimension direction, P when already aligned
    if (hdr_i.dst_x > my_x_i) begin
      x_dir = E;
    end else if (hdr_i.dst_x < my_x_i) begin
      x_dir = W;
    end else begin
      x_dir = P;
    end

    if (hdr_i.dst_y > my_y_i) begin
      y_dir = S;
    end else if (hdr_i.dst_y < my_y_i) begin
      y_dir = N;
    end else begin
      y_dir = P;
    end

    // finish the first dimension before turning
    if (xy_order_p != 0) begin
      sel_dir = (x_dir != P) ? x_dir : y_dir;
    end else begin
      sel_dir = (y_dir != P) ? y_dir : x_dir;
    end

    req_o          = '0;
    req_o[sel_dir] = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/mesh_switch_alloc.sv ====
/* switch allocator, one round-robin arbiter per output port,
   grants stay locked while the output is stalled */

`timescale 1ns/1ps
`default_nettype none

module mesh_switch_alloc (
  input  logic clk_i,
  input  logic arst_n_i,

  // req_i[input][output], grant_o[output][input]
  input  logic [mesh_pkg::num_dirs_lp-1:0][mesh_pkg::num_dirs_lp-1:0] req_i,
  input  logic [mesh_pkg::num_dirs_lp-1:0]                            out_ready_i,
  output logic [mesh_pkg::num_dirs_lp-1:0][mesh_pkg::num_dirs_lp-1:0] grant_o,
  output logic [mesh_pkg::num_dirs_lp-1:0]                            pop_o
);

  import mesh_pkg::*;

  dir_e                   ptr_r      [num_dirs_lp];
  dir_e                   hold_dir_r [num_dirs_lp];
  logic [num_dirs_lp-1:0] hold_r;

  dir_e                   arb_dir [num_dirs_lp];
  logic [num_dirs_lp-1:0] arb_v;
  dir_e                   win_dir [num_dirs_lp];
  logic [num_dirs_lp-1:0] win_v;

  // first requester at or after the pointer
  always_comb begin
    int   idx;
    logic found;
    for (int o = 0; o < num_dirs_lp; o++) begin
      arb_dir[o] = P;
      found      = 1'b0;
      for (int k = 0; k < num_dirs_lp; k++) begin
        idx = (int'(ptr_r[o]) + k) % num_dirs_lp;
        if (!found && req_i[idx][o]) begin
          arb_dir[o] = dir_e'(idx);
          found      = 1'b1;
        end
      end
      arb_v[o] = found;
    end
  end

  // a stalled output keeps its winner so v and data hold steady
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < num_dirs_lp; o++) begin
      win_dir[o] = hold_r[o] ? hold_dir_r[o] : arb_dir[o];
      win_v[o]   = hold_r[o] | arb_v[o];
      grant_o[o] = '0;
      if (win_v[o]) begin
        grant_o[o][win_dir[o]] = 1'b1;
      end
      pop_o = pop_o | (grant_o[o] & {num_dirs_lp{out_ready_i[o]}});
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_r <= '0;
      for (int o = 0; o < num_dirs_lp; o++) begin
        ptr_r[o]      <= P;
        hold_dir_r[o] <= P;
      end
    end else begin
      for (int o = 0; o < num_dirs_lp; o++) begin
        if (win_v[o] && out_ready_i[o]) begin
          // pointer moves past the winner only on a transfer
          ptr_r[o]  <= (win_dir[o] == S) ? P : dir_e'(win_dir[o] + 3'd1);
          hold_r[o] <= 1'b0;
        end else if (win_v[o]) begin
          hold_r[o]     <= 1'b1;
          hold_dir_r[o] <= win_dir[o];
        end
      end
    end
  end

  // an input head goes to one output only
  for (genvar i = 0; i < num_dirs_lp; i++) begin : g_in_chk
    logic [num_dirs_lp-1:0] gnt_col;
    for (genvar o = 0; o < num_dirs_lp; o++) begin : g_col
      assign gnt_col[o] = grant_o[o][i];
    end
    a_one_grant_per_input: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) $onehot0(gnt_col)
    );
  end

endmodule

`default_nettype wire

// ==== source/mesh_router.sv ====
/* buffered five-port mesh router,
   input FIFOs, route decoders, switch allocator and output crossbar */

`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
  parameter int width_p    = 16,
  parameter int xy_order_p = 1
) (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  mesh_pkg::x_cord_t                               my_x_i,
  input  mesh_pkg::y_cord_t                               my_y_i,

  input  logic [mesh_pkg::num_dirs_lp-1:0]                link_v_i,
  input  logic [mesh_pkg::num_dirs_lp-1:0][width_p-1:0]   link_data_i,
  output logic [mesh_pkg::num_dirs_lp-1:0]                link_ready_o,

  output logic [mesh_pkg::num_dirs_lp-1:0]                link_v_o,
  output logic [mesh_pkg::num_dirs_lp-1:0][width_p-1:0]   link_data_o,
  input  logic [mesh_pkg::num_dirs_lp-1:0]                link_ready_i
);

  import mesh_pkg::*;

  logic [num_dirs_lp-1:0]                  head_v;
  logic [num_dirs_lp-1:0][width_p-1:0]     head_data;
  logic [num_dirs_lp-1:0][num_dirs_lp-1:0] dec_req;
  logic [num_dirs_lp-1:0][num_dirs_lp-1:0] req;
  logic [num_dirs_lp-1:0][num_dirs_lp-1:0] grant;
  logic [num_dirs_lp-1:0]                  pop;

  for (genvar i = 0; i < num_dirs_lp; i++) begin : g_in
    mesh_hdr_s hdr;

    mesh_input_fifo #(
      .width_p(width_p)
    ) fifo (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .enq_v_i    (link_v_i[i]),
      .enq_data_i (link_data_i[i]),
      .enq_ready_o(link_ready_o[i]),
      .deq_v_o    (head_v[i]),
      .deq_data_o (head_data[i]),
      .deq_yumi_i (pop[i])
    );

    // header sits in the top bits of every packet
    assign hdr = mesh_hdr_s'(head_data[i][width_p-1 -: hdr_width_lp]);

    mesh_route_decode #(
      .xy_order_p(xy_order_p)
    ) decode (
      .hdr_i (hdr),
      .my_x_i(my_x_i),
      .my_y_i(my_y_i),
      .req_o (dec_req[i])
    );

    assign req[i] = head_v[i] ? dec_req[i] : '0;

    // mesh inputs never bounce back out the link they arrived on
    if (i != int'(P)) begin : g_no_uturn
      a_no_uturn: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) head_v[i] |-> !dec_req[i][i]
      );
    end
  end

  mesh_switch_alloc alloc (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req),
    .out_ready_i(link_ready_i),
    .grant_o    (grant),
    .pop_o      (pop)
  );

  // and-or crossbar driven by the one-hot grants
  always_comb begin
    for (int o = 0; o < num_dirs_lp; o++) begin
      link_v_o[o]    = |grant[o];
      link_data_o[o] = '0;
      for (int i = 0; i < num_dirs_lp; i++) begin
        if (grant[o][i]) begin
          link_data_o[o] = link_data_o[o] | head_data[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mesh_node.sv ====
/* mesh node top level,
   forward (x then y) and reverse (y then x) routers on shared ports */

`timescale 1ns/1ps
`default_nettype none

module mesh_node (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  mesh_pkg::x_cord_t                                global_x_i,
  input  mesh_pkg::y_cord_t                                global_y_i,

  // request network, indexed by port direction
  input  mesh_pkg::fwd_link_s [mesh_pkg::num_dirs_lp-1:0]  fwd_link_i,
  output logic                [mesh_pkg::num_dirs_lp-1:0]  fwd_ready_o,
  output mesh_pkg::fwd_link_s [mesh_pkg::num_dirs_lp-1:0]  fwd_link_o,
  input  logic                [mesh_pkg::num_dirs_lp-1:0]  fwd_ready_i,

  // response network
  input  mesh_pkg::rev_link_s [mesh_pkg::num_dirs_lp-1:0]  rev_link_i,
  output logic                [mesh_pkg::num_dirs_lp-1:0]  rev_ready_o,
  output mesh_pkg::rev_link_s [mesh_pkg::num_dirs_lp-1:0]  rev_link_o,
  input  logic                [mesh_pkg::num_dirs_lp-1:0]  rev_ready_i
);

  import mesh_pkg::*;

  logic [num_dirs_lp-1:0]                       fwd_v_li, fwd_v_lo;
  logic [num_dirs_lp-1:0][fwd_pkt_width_lp-1:0] fwd_data_li, fwd_data_lo;
  logic [num_dirs_lp-1:0]                       rev_v_li, rev_v_lo;
  logic [num_dirs_lp-1:0][rev_pkt_width_lp-1:0] rev_data_li, rev_data_lo;

  // split link structs into router arrays and rebuild them on the way out
  for (genvar d = 0; d < num_dirs_lp; d++) begin : g_link
    assign fwd_v_li[d]       = fwd_link_i[d].v;
    assign fwd_data_li[d]    = fwd_link_i[d].pkt;
    assign fwd_link_o[d].v   = fwd_v_lo[d];
    assign fwd_link_o[d].pkt = fwd_pkt_s'(fwd_data_lo[d]);

    assign rev_v_li[d]       = rev_link_i[d].v;
    assign rev_data_li[d]    = rev_link_i[d].pkt;
    assign rev_link_o[d].v   = rev_v_lo[d];
    assign rev_link_o[d].pkt = rev_pkt_s'(rev_data_lo[d]);
  end

  mesh_router #(
    .width_p   (fwd_pkt_width_lp),
    .xy_order_p(1)
  ) fwd (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .my_x_i      (global_x_i),
    .my_y_i      (global_y_i),
    .link_v_i    (fwd_v_li),
    .link_data_i (fwd_data_li),
    .link_ready_o(fwd_ready_o),
    .link_v_o    (fwd_v_lo),
    .link_data_o (fwd_data_lo),
    .link_ready_i(fwd_ready_i)
  );

  mesh_router #(
    .width_p   (rev_pkt_width_lp),
    .xy_order_p(0)
  ) rev (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .my_x_i      (global_x_i),
    .my_y_i      (global_y_i),
    .link_v_i    (rev_v_li),
    .link_data_i (rev_data_li),
    .link_ready_o(rev_ready_o),
    .link_v_o    (rev_v_lo),
    .link_data_o (rev_data_lo),
    .link_ready_i(rev_ready_i)
  );

endmodule

`default_nettype wire

// ==== verif/mesh_node_tb.sv ====
/* testbench for the mesh node with random traffic on both networks,
   reference routing, scoreboard, stalled output and round-robin checks, watchdog */

`timescale 1ns/1ps
`default_nettype none

module mesh_node_tb;

  import mesh_pkg::*;

  localparam int my_x_lp           = 3;
  localparam int my_y_lp           = 4;
  localparam int pkts_per_in_lp    = 40;
  localparam int total_pkts_lp     = 2 * num_dirs_lp * pkts_per_in_lp + 40;
  // every packet may wait behind all five inputs plus back-pressure
  localparam int timeout_cycles_lp = total_pkts_lp * num_dirs_lp * 4 + 2000;
  localparam int drain_cycles_lp   = 500;
  localparam int qw_lp             = fwd_pkt_width_lp;

  logic                   clk;
  logic                   arst_n;
  fwd_link_s [num_dirs_lp-1:0] fwd_in;
  fwd_link_s [num_dirs_lp-1:0] fwd_out;
  logic [num_dirs_lp-1:0] fwd_in_ready;
  logic [num_dirs_lp-1:0] fwd_out_ready;
  rev_link_s [num_dirs_lp-1:0] rev_in;
  rev_link_s [num_dirs_lp-1:0] rev_out;
  logic [num_dirs_lp-1:0] rev_in_ready;
  logic [num_dirs_lp-1:0] rev_out_ready;

  // expected packets indexed by net * num_dirs_lp + output port
  logic [qw_lp-1:0] exp_q [2*num_dirs_lp][$];
  int               mismatch_cnt;
  int               other_cnt;
  int               seq;
  int               seed_val;
  logic             rr_check;
  int               rr_last;

  mesh_node dut (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .global_x_i (x_cord_t'(my_x_lp)),
    .global_y_i (y_cord_t'(my_y_lp)),
    .fwd_link_i (fwd_in),
    .fwd_ready_o(fwd_in_ready),
    .fwd_link_o (fwd_out),
    .fwd_ready_i(fwd_out_ready),
    .rev_link_i (rev_in),
    .rev_ready_o(rev_in_ready),
    .rev_link_o (rev_out),
    .rev_ready_i(rev_out_ready)
  );

  always #20 clk = ~clk;

  // output port by dimension order with 0=P 1=W 2=E 3=N 4=S
  function automatic int expected_port(input bit x_first, input int dst_x, input int dst_y);
    int x_port;
    int y_port;
    x_port = (dst_x > my_x_lp) ? 2 : ((dst_x < my_x_lp) ? 1 : 0);
    y_port = (dst_y > my_y_lp) ? 4 : ((dst_y < my_y_lp) ? 3 : 0);
    if (x_first) begin
      return (x_port != 0) ? x_port : y_port;
    end
    return (y_port != 0) ? y_port : x_port;
  endfunction

  // random destination that does not turn back on a mesh input
  function automatic void pick_dst(input bit x_first, input int src,
                                   output int dx, output int dy);
    do begin
      dx = $urandom_range(0, 7);
      dy = $urandom_range(0, 7);
    end while (src != int'(P) && expected_port(x_first, dx, dy) == src);
  endfunction

  // data carries the source input on top and a unique sequence number
  function automatic fwd_pkt_s build_fwd(input int src, input int dx, input int dy);
    fwd_pkt_s pkt;
    pkt.hdr.dst_x = x_cord_t'(dx);
    pkt.hdr.dst_y = y_cord_t'(dy);
    pkt.op        = op_t'($urandom);
    pkt.src_x     = x_cord_t'($urandom);
    pkt.src_y     = y_cord_t'($urandom);
    pkt.addr      = addr_t'($urandom);
    pkt.data      = {3'(src), 29'(seq)};
    seq++;
    return pkt;
  endfunction

  function automatic rev_pkt_s build_rev(input int src, input int dx, input int dy);
    rev_pkt_s pkt;
    pkt.hdr.dst_x = x_cord_t'(dx);
    pkt.hdr.dst_y = y_cord_t'(dy);
    pkt.data      = {3'(src), 29'(seq)};
    seq++;
    return pkt;
  endfunction

  // called right after a rising edge so it sees the values of that edge
  task automatic log_accepted(output logic [num_dirs_lp-1:0] fwd_acc,
                              output logic [num_dirs_lp-1:0] rev_acc);
    int port;
    for (int d = 0; d < num_dirs_lp; d++) begin
      fwd_acc[d] = fwd_in[d].v & fwd_in_ready[d];
      rev_acc[d] = rev_in[d].v & rev_in_ready[d];
      if (fwd_acc[d]) begin
        port = expected_port(1'b1, int'(fwd_in[d].pkt.hdr.dst_x),
                             int'(fwd_in[d].pkt.hdr.dst_y));
        exp_q[port].push_back(qw_lp'(fwd_in[d].pkt));
      end
      if (rev_acc[d]) begin
        port = expected_port(1'b0, int'(rev_in[d].pkt.hdr.dst_x),
                             int'(rev_in[d].pkt.hdr.dst_y));
        exp_q[num_dirs_lp + port].push_back(qw_lp'(rev_in[d].pkt));
      end
    end
  endtask

  task automatic verify_reset_state();
    for (int d = 0; d < num_dirs_lp; d++) begin
      if (fwd_out[d].v !== 1'b0) begin
        mismatch_cnt++;
        $display("MISMATCH fwd_link_o[%0d].v got %h expected %h", d, fwd_out[d].v, 1'b0);
      end
      if (rev_out[d].v !== 1'b0) begin
        mismatch_cnt++;
        $display("MISMATCH rev_link_o[%0d].v got %h expected %h", d, rev_out[d].v, 1'b0);
      end
      if (fwd_in_ready[d] !== 1'b1) begin
        mismatch_cnt++;
        $display("MISMATCH fwd_ready_o[%0d] got %h expected %h", d, fwd_in_ready[d], 1'b1);
      end
      if (rev_in_ready[d] !== 1'b1) begin
        mismatch_cnt++;
        $display("MISMATCH rev_ready_o[%0d] got %h expected %h", d, rev_in_ready[d], 1'b1);
      end
    end
  endtask

  task automatic send_random_traffic();
    int                     fwd_left [num_dirs_lp];
    int                     rev_left [num_dirs_lp];
    bit                     fwd_pend [num_dirs_lp];
    bit                     rev_pend [num_dirs_lp];
    logic [num_dirs_lp-1:0] fwd_acc;
    logic [num_dirs_lp-1:0] rev_acc;
    int                     dx;
    int                     dy;
    bit                     busy;
    for (int d = 0; d < num_dirs_lp; d++) begin
      fwd_left[d] = pkts_per_in_lp;
      rev_left[d] = pkts_per_in_lp;
      fwd_pend[d] = 1'b0;
      rev_pend[d] = 1'b0;
    end
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
      busy = 1'b0;
      for (int d = 0; d < num_dirs_lp; d++) begin
        fwd_out_ready[d] <= ($urandom_range(0, 9) < 7);
        rev_out_ready[d] <= ($urandom_range(0, 9) < 7);
        if (fwd_acc[d]) fwd_pend[d] = 1'b0;
        if (rev_acc[d]) rev_pend[d] = 1'b0;
        if (!fwd_pend[d] && fwd_left[d] > 0 && $urandom_range(0, 3) != 0) begin
          pick_dst(1'b1, d, dx, dy);
          fwd_in[d].pkt <= build_fwd(d, dx, dy);
          fwd_in[d].v   <= 1'b1;
          fwd_pend[d] = 1'b1;
          fwd_left[d]--;
        end else if (!fwd_pend[d]) begin
          fwd_in[d].v <= 1'b0;
        end
        if (!rev_pend[d] && rev_left[d] > 0 && $urandom_range(0, 3) != 0) begin
          pick_dst(1'b0, d, dx, dy);
          rev_in[d].pkt <= build_rev(d, dx, dy);
          rev_in[d].v   <= 1'b1;
          rev_pend[d] = 1'b1;
          rev_left[d]--;
        end else if (!rev_pend[d]) begin
          rev_in[d].v <= 1'b0;
        end
        busy |= fwd_pend[d] | rev_pend[d] | (fwd_left[d] > 0) | (rev_left[d] > 0);
      end
    end
  endtask

  // W input heads east while the E output is stalled
  task automatic stall_east_output();
    logic [num_dirs_lp-1:0] fwd_acc;
    logic [num_dirs_lp-1:0] rev_acc;
    int                     accepted;
    accepted = 0;
    @(posedge clk);
    fwd_out_ready <= ~(num_dirs_lp'(1) << int'(E));
    fwd_in[W].pkt <= build_fwd(int'(W), 5, $urandom_range(0, 7));
    fwd_in[W].v   <= 1'b1;
    while (accepted < 2) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
      if (fwd_acc[W]) begin
        accepted++;
        fwd_in[W].pkt <= build_fwd(int'(W), 6, $urandom_range(0, 7));
      end
    end
    repeat (4) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
      if (fwd_in_ready[W] !== 1'b0) begin
        mismatch_cnt++;
        $display("MISMATCH fwd_ready_o[%0d] got %h expected %h", int'(W), fwd_in_ready[W], 1'b0);
      end
    end
    fwd_out_ready <= '1;
    fwd_acc = '0;
    while (!fwd_acc[W]) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
    end
    fwd_in[W].v <= 1'b0;
  endtask

  // all mesh inputs keep their FIFOs full with packets for the local port
  task automatic contend_for_local();
    logic [num_dirs_lp-1:0] fwd_acc;
    logic [num_dirs_lp-1:0] rev_acc;
    logic [num_dirs_lp-1:0] live;
    @(posedge clk);
    fwd_out_ready <= ~(num_dirs_lp'(1) << int'(P));
    for (int d = 1; d < num_dirs_lp; d++) begin
      fwd_in[d].pkt <= build_fwd(d, my_x_lp, my_y_lp);
      fwd_in[d].v   <= 1'b1;
    end
    for (int c = 0; c < 40; c++) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
      if (c == 6) begin
        rr_check      <= 1'b1;
        fwd_out_ready <= '1;
      end
      for (int d = 1; d < num_dirs_lp; d++) begin
        if (fwd_acc[d]) fwd_in[d].pkt <= build_fwd(d, my_x_lp, my_y_lp);
      end
    end
    rr_check <= 1'b0;
    live = ~num_dirs_lp'(1);
    while (live != '0) begin
      @(posedge clk);
      log_accepted(fwd_acc, rev_acc);
      for (int d = 1; d < num_dirs_lp; d++) begin
        if (fwd_acc[d]) begin
          fwd_in[d].v <= 1'b0;
          live[d] = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    int left;
    int c;
    c = 0;
    @(posedge clk);
    fwd_out_ready <= '1;
    rev_out_ready <= '1;
    do begin
      @(negedge clk);
      c++;
      left = 0;
      for (int q = 0; q < 2 * num_dirs_lp; q++) left += exp_q[q].size();
    end while (left != 0 && c < drain_cycles_lp);
    for (int q = 0; q < 2 * num_dirs_lp; q++) begin
      for (int i = 0; i < exp_q[q].size(); i++) begin
        other_cnt++;
        $display("packet %h for %s output %0d never arrived", exp_q[q][i],
                 (q < num_dirs_lp) ? "fwd" : "rev", q % num_dirs_lp);
      end
      exp_q[q].delete();
    end
  endtask

  // order only matters among packets of one input
  task automatic score_output(input int net, input int o, input logic [qw_lp-1:0] got);
    int q;
    int hit;
    q   = net * num_dirs_lp + o;
    hit = -1;
    for (int i = 0; i < exp_q[q].size(); i++) begin
      if (hit < 0 && exp_q[q][i] == got) hit = i;
    end
    if (exp_q[q].size() == 0) begin
      other_cnt++;
      $display("unexpected packet %h on %s output %0d", got, net ? "rev" : "fwd", o);
    end else if (hit < 0) begin
      mismatch_cnt++;
      $display("MISMATCH %s_link_o[%0d].pkt got %h expected %h",
               net ? "rev" : "fwd", o, got, exp_q[q][0]);
    end else begin
      for (int i = 0; i < hit; i++) begin
        if (exp_q[q][i][31:29] == got[31:29]) begin
          other_cnt++;
          $display("packet %h from input %0d overtook an older one on %s output %0d",
                   got, got[31:29], net ? "rev" : "fwd", o);
        end
      end
      exp_q[q].delete(hit);
    end
  endtask

  always @(posedge clk) begin
    int src;
    int want;
    if (arst_n) begin
      for (int o = 0; o < num_dirs_lp; o++) begin
        if (fwd_out[o].v && fwd_out_ready[o]) score_output(0, o, qw_lp'(fwd_out[o].pkt));
        if (rev_out[o].v && rev_out_ready[o]) score_output(1, o, qw_lp'(rev_out[o].pkt));
      end
      if (!rr_check) begin
        rr_last = -1;
      end else if (fwd_out[P].v && fwd_out_ready[P]) begin
        src  = int'(fwd_out[P].pkt.data[31:29]);
        // P never requests here so S wraps to W
        want = (rr_last == int'(S)) ? int'(W) : rr_last + 1;
        if (rr_last >= 0 && src != want) begin
          mismatch_cnt++;
          $display("MISMATCH fwd_link_o[0].pkt.data[31:29] got %h expected %h", src, want);
        end
        rr_last = src;
      end
    end
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("watchdog expired after %0d cycles, traffic did not finish", timeout_cycles_lp);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    seed_val      = $urandom(32'h5812_c23c);
    clk           = 1'b0;
    arst_n        = 1'b0;
    fwd_in        = '0;
    rev_in        = '0;
    fwd_out_ready = '0;
    rev_out_ready = '0;
    rr_check      = 1'b0;
    rr_last       = -1;
    mismatch_cnt  = 0;
    other_cnt     = 0;
    seq           = 0;

    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    verify_reset_state();

    send_random_traffic();
    wait_drain();
    stall_east_output();
    wait_drain();
    contend_for_local();
    wait_drain();

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/mesh_pkg.sv
source/mesh_input_fifo.sv
source/mesh_route_decode.sv
source/mesh_switch_alloc.sv
source/mesh_router.sv
source/mesh_node.sv
verif/mesh_node_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mesh node testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

top=mesh_node_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -Mdir "$build_dir" -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/V$top" 2>&1 | tee "$log"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST FAIL$" "$log"; then
  echo "simulation reported failure, see $log"
  exit 1
fi
if ! grep -q "^TEST PASS$" "$log"; then
  echo "simulation ended without a result, see $log"
  exit 1
fi
exit 0
